//--- Makefile
# Verilator build and run for the neuron core testbench

VERILATOR ?= verilator
TOP       ?= tb_neuron_core
DUT_TOP   ?= neuron_core
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bf16_add.sv
`timescale 1ns/100ps

module bf16_add (
	input  npu_pkg::bf16_t a,
	input  npu_pkg::bf16_t b,
	output npu_pkg::bf16_t sum
);
	import npu_pkg::*;

	bf16_t             big;        // Operand with the larger magnitude
	bf16_t             small_op;
	logic              a_zero;
	logic              b_zero;
	logic [7:0]        exp_diff;
	logic [7:0]        m_big;      // Mantissas with the hidden bit restored
	logic [7:0]        m_small;
	logic [8:0]        m_sum;      // Bit 8 is the carry of an effective add
	logic [3:0]        lz;         // Leading zeros of m_sum[7:0]
	logic [7:0]        m_norm;
	logic signed [9:0] exp_res;    // Wide enough to see underflow and overflow

	// Exponent zero covers zero and flushed denormals
	assign a_zero = (a.exp == 8'd0);
	assign b_zero = (b.exp == 8'd0);

	always_comb begin
		if ({a.exp, a.man} >= {b.exp, b.man}) begin
			big      = a;
			small_op = b;
		end else begin
			big      = b;
			small_op = a;
		end
	end

	assign exp_diff = big.exp - small_op.exp;
	assign m_big    = {1'b1, big.man};

	// Bits shifted out are simply lost
	assign m_small = (exp_diff > 8'd7) ? 8'd0 : ({1'b1, small_op.man} >> exp_diff);

	assign m_sum = (big.sign == small_op.sign) ? ({1'b0, m_big} + {1'b0, m_small})
	                                           : ({1'b0, m_big} - {1'b0, m_small});

	// Highest set bit wins since the loop runs upward
	always_comb begin
		lz = 4'd8;
		for (int i = 0; i < 8; i++) begin
			if (m_sum[i]) begin
				lz = 4'(7 - i);
			end
		end
	end

	always_comb begin
		if (m_sum[8]) begin
			m_norm  = m_sum[8:1];                  // Carry out needs one right shift
			exp_res = {2'b00, big.exp} + 10'sd1;
		end else begin
			m_norm  = m_sum[7:0] << lz;            // Cancellation needs a left shift
			exp_res = {2'b00, big.exp} - {6'd0, lz};
		end
	end

	always_comb begin
		if (a_zero && b_zero) begin
			sum = BF16_ZERO;
		end else if (a_zero) begin
			sum = b;
		end else if (b_zero) begin
			sum = a;
		end else if (m_sum == 9'd0) begin
			sum = BF16_ZERO;                       // Exact cancellation gives +0
		end else if (exp_res <= 10'sd0) begin
			sum = BF16_ZERO;                       // Underflow flushes
		end else if (exp_res >= 10'sd255) begin
			sum = {big.sign, BF16_MAX[14:0]};      // Saturate with the result sign
		end else begin
			sum = {big.sign, exp_res[7:0], m_norm[6:0]};   // Truncated mantissa
		end
	end

endmodule

//--- dot_lane.sv
`timescale 1ns/100ps

module dot_lane #(
	parameter int LANE_BASE = 0
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         start,
	input  logic [npu_pkg::LANE_LEN-1:0] bits,
	output logic [npu_pkg::ADDR_W-1:0]   rd_addr,
	input  npu_pkg::bf16_t               rd_data,
	output npu_pkg::lane_res_t           res
);
	import npu_pkg::*;

	localparam int                IDX_W     = $clog2(LANE_LEN);
	localparam logic [ADDR_W-1:0] BASE_ADDR = ADDR_W'(LANE_BASE);

	logic [LANE_LEN-1:0] slice;      // Activation bits of this lane
	logic [IDX_W-1:0]    idx;
	logic                issue;      // Address on rd_addr
	logic                fetch;      // Matching weight on rd_data
	logic                add_en;     // Term register holds a real term
	logic                bit_d;      // Activation bit aligned with rd_data
	bf16_t               term;
	bf16_t               acc;
	bf16_t               acc_next;
	logic                done;
	logic                busy;

	assign rd_addr = BASE_ADDR + ADDR_W'(idx);
	assign busy    = issue | fetch | add_en;

	bf16_add u_add (
		.a   (acc),
		.b   (term),
		.sum (acc_next)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			issue  <= 1'b0;
			fetch  <= 1'b0;
			add_en <= 1'b0;
			done   <= 1'b0;
			idx    <= '0;
			acc    <= BF16_ZERO;
		end else begin
			fetch  <= issue;
			add_en <= fetch;
			done   <= add_en & ~fetch;               // Last term goes in now
			if (start) begin
				issue <= 1'b1;
				idx   <= '0;
				acc   <= BF16_ZERO;
			end else begin
				if (issue) begin
					idx <= idx + 1'b1;
					if (idx == IDX_W'(LANE_LEN - 1)) begin
						issue <= 1'b0;
					end
				end
				if (add_en) begin
					acc <= acc_next;                 // Ascending index order
				end
			end
		end
	end

	// Slice capture and term pipeline
	always_ff @(posedge clk) begin
		if (start) begin
			slice <= bits;
		end
		bit_d <= slice[idx];
		term  <= (fetch && bit_d) ? rd_data : BF16_ZERO;   // Binary multiply as a mux
	end

	assign res = {acc, done};

	a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
		start |-> !busy);

	// Done only at the fixed latency after start
	a_done_pulse: assert property (@(posedge clk) disable iff (reset)
		done |-> $past(start, LANE_LEN + 3));

endmodule

//--- neuron_core.sv
`timescale 1ns/100ps

module neuron_core (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         req,
	input  logic [npu_pkg::N_INPUTS-1:0] data,
	output logic                         ack,
	output npu_pkg::bf16_t               result
);
	import npu_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_BUSY,
		S_ACK
	} state_t;

	state_t              state;
	logic [N_INPUTS-1:0] word;          // Captured activation word
	logic                start;
	logic                seen_0;        // Sticky done flags
	logic                seen_1;
	logic                both_done;
	logic [ADDR_W-1:0]   rd_addr_0;
	logic [ADDR_W-1:0]   rd_addr_1;
	bf16_t               rd_data_0;
	bf16_t               rd_data_1;
	lane_res_t           res_0;
	lane_res_t           res_1;
	bf16_t               comb_sum;

	assign both_done = (seen_0 | res_0.done) & (seen_1 | res_1.done);

	weight_rom u_rom (
		.clk    (clk),
		.addr_a (rd_addr_0),
		.data_a (rd_data_0),
		.addr_b (rd_addr_1),
		.data_b (rd_data_1)
	);

	dot_lane #(.LANE_BASE(0)) u_lane_0 (
		.clk     (clk),
		.reset   (reset),
		.start   (start),
		.bits    (word[LANE_LEN-1:0]),
		.rd_addr (rd_addr_0),
		.rd_data (rd_data_0),
		.res     (res_0)
	);

	dot_lane #(.LANE_BASE(LANE_LEN)) u_lane_1 (
		.clk     (clk),
		.reset   (reset),
		.start   (start),
		.bits    (word[N_INPUTS-1:LANE_LEN]),
		.rd_addr (rd_addr_1),
		.rd_data (rd_data_1),
		.res     (res_1)
	);

	bf16_add u_combine (
		.a   (res_0.sum),
		.b   (res_1.sum),
		.sum (comb_sum)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state  <= S_IDLE;
			start  <= 1'b0;
			seen_0 <= 1'b0;
			seen_1 <= 1'b0;
			ack    <= 1'b0;
			result <= BF16_ZERO;
		end else begin
			start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (req) begin
						start  <= 1'b1;               // Lanes load the word next edge
						seen_0 <= 1'b0;
						seen_1 <= 1'b0;
						state  <= S_BUSY;
					end
				end
				S_BUSY: begin
					if (both_done) begin
						result <= comb_sum;
						ack    <= 1'b1;
						state  <= S_ACK;
					end else begin
						seen_0 <= seen_0 | res_0.done;
						seen_1 <= seen_1 | res_1.done;
					end
				end
				S_ACK: begin
					if (!req) begin
						ack   <= 1'b0;                // Held while req stays high
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && req) begin
			word <= data;
		end
	end

	a_ack_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> req);

	a_ack_fall: assert property (@(posedge clk) disable iff (reset)
		$fell(ack) |-> !$past(req));

	a_result_hold: assert property (@(posedge clk) disable iff (reset)
		(ack && $past(ack)) |-> $stable(result));

endmodule

//--- npu_pkg.sv
package npu_pkg;

	// One bfloat16 number
	typedef struct packed {
		logic       sign;
		logic [7:0] exp;
		logic [6:0] man;
	} bf16_t;

	// Partial sum handed from a lane to the top
	typedef struct packed {
		bf16_t sum;
		logic  done;   // One-cycle pulse, sum valid from here on
	} lane_res_t;

	localparam int N_INPUTS = 64;   // Activation word width
	localparam int LANE_LEN = 32;   // Bits walked by one lane
	localparam int ADDR_W   = 6;    // Weight address width

	localparam bf16_t BF16_ZERO = 16'h0000;   // Positive zero
	localparam bf16_t BF16_MAX  = 16'h7F7F;   // Largest finite magnitude

	localparam string WEIGHT_FILE = "weights.hex";

endpackage

//--- tb_bf16_model.svh
`ifndef TB_BF16_MODEL_SVH
`define TB_BF16_MODEL_SVH

// Reference bfloat16 add, truncating, denormals flush, overflow saturates
function automatic logic [15:0] bf16_add_ref(input logic [15:0] x, input logic [15:0] y);
	logic [15:0] hi;     // Larger magnitude operand
	logic [15:0] lo;
	int          e;
	int          shift;
	int          hi_m;
	int          lo_m;
	int          m;
	if (x[14:7] == 8'd0 && y[14:7] == 8'd0) begin
		return 16'h0000;
	end
	if (x[14:7] == 8'd0) begin
		return y;
	end
	if (y[14:7] == 8'd0) begin
		return x;
	end
	if (x[14:0] >= y[14:0]) begin
		hi = x;
		lo = y;
	end else begin
		hi = y;
		lo = x;
	end
	e     = int'(hi[14:7]);
	shift = e - int'(lo[14:7]);
	hi_m  = int'({1'b1, hi[6:0]});
	lo_m  = (shift > 7) ? 0 : (int'({1'b1, lo[6:0]}) >> shift);   // Shifted-out bits dropped
	m     = (hi[15] == lo[15]) ? hi_m + lo_m : hi_m - lo_m;
	if (m == 0) begin
		return 16'h0000;
	end
	while (m > 255) begin
		m = m >> 1;
		e++;
	end
	while (m < 128) begin
		m = m << 1;
		e--;
	end
	if (e <= 0) begin
		return 16'h0000;
	end
	if (e >= 255) begin
		return {hi[15], 15'h7F7F};
	end
	return {hi[15], 8'(e), 7'(m)};
endfunction

// Lane partial sum over ascending indices, uses the testbench weights array
function automatic logic [15:0] lane_sum_ref(input logic [N_INPUTS-1:0] word, input int base);
	logic [15:0] acc;
	acc = 16'h0000;
	for (int i = 0; i < LANE_LEN; i++) begin
		acc = bf16_add_ref(acc, word[base + i] ? weights[base + i] : 16'h0000);
	end
	return acc;
endfunction

function automatic logic [15:0] neuron_ref(input logic [N_INPUTS-1:0] word);
	return bf16_add_ref(lane_sum_ref(word, 0), lane_sum_ref(word, LANE_LEN));
endfunction

`endif

//--- tb_neuron_core.sv
`timescale 1ns/100ps

module tb_neuron_core;
	import npu_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int ACK_LAT    = LANE_LEN + 5;   // Capture edge to edge that samples ack high
	localparam int WAIT_LIMIT = 4 * LANE_LEN;
	localparam int MAX_HOLD   = 15;
	localparam int N_HALF     = 10;
	localparam int N_RANDOM   = 200;
	localparam int N_HS       = 10;
	localparam int N_BP       = 20;
	localparam int N_TRANS    = 2 + N_INPUTS + 2 * N_HALF + N_RANDOM + N_HS + N_BP;
	localparam int WATCHDOG_CYCLES = N_TRANS * (LANE_LEN + 20) + 500;
	localparam logic [N_INPUTS-1:0] LOW_MASK = {{LANE_LEN{1'b0}}, {LANE_LEN{1'b1}}};

	logic                clk;
	logic                reset;
	logic                req;
	logic [N_INPUTS-1:0] data;
	logic                ack;
	bf16_t               result;

	logic [15:0]         weights [0:N_INPUTS-1];
	logic [N_INPUTS-1:0] word;
	int                  seed;
	int                  hold;
	int                  checks;
	int                  errors;
	int                  mark_checks;
	int                  mark_errors;
	int                  n_tests;

	`include "tb_bf16_model.svh"

	neuron_core uut (
		.clk    (clk),
		.reset  (reset),
		.req    (req),
		.data   (data),
		.ack    (ack),
		.result (result)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [N_INPUTS-1:0] random_word();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic report_test(input string name);
		n_tests++;
		$display("%s: %0d checks, %0d errors", name, checks - mark_checks, errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
	endtask

	// Full four-phase handshake, req held for hold extra cycles after ack
	task automatic run_word(input logic [N_INPUTS-1:0] w, input logic [15:0] expected,
			input int extra);
		int          lat;
		int          fall;
		logic [15:0] held;
		@(posedge clk);
		data <= w;
		req  <= 1'b1;
		@(negedge clk);
		lat = 0;
		while (!ack && lat < WAIT_LIMIT) begin
			@(negedge clk);
			lat++;
		end
		if (!ack) begin
			errors++;
			$display("Timeout at %0d ns: ack never rose for word %h", $time, w);
		end
		checks += 2;
		assert (lat == ACK_LAT) else begin
			errors++;
			$display("[ERROR] %0d ns: word %h ack after %0d cycles, expected %0d",
				$time, w, lat, ACK_LAT);
		end
		assert (result === expected) else begin
			errors++;
			$display("[ERROR] %0d ns: word %h expected %h got %h", $time, w, expected, result);
		end
		held = result;
		repeat (extra) begin
			@(posedge clk);
			data <= random_word();                  // Must not be taken while ack is high
			@(negedge clk);
			checks++;
			assert (ack === 1'b1 && result === held) else begin
				errors++;
				$display("[ERROR] %0d ns: ack %b result %h while req held, expected 1 and %h",
					$time, ack, result, held);
			end
		end
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		fall = 0;
		while (ack && fall < WAIT_LIMIT) begin
			@(negedge clk);
			fall++;
		end
		checks += 2;
		assert (fall == 1) else begin
			errors++;
			$display("[ERROR] %0d ns: ack fell %0d cycles after req drop, expected 1", $time, fall);
		end
		assert (result === expected) else begin
			errors++;
			$display("[ERROR] %0d ns: result %h after ack fell, expected %h", $time, result, expected);
		end
	endtask

	// Req stays low, ack must stay low and result must hold
	task automatic idle_check(input int cycles, input logic [15:0] expected);
		repeat (cycles) begin
			@(negedge clk);
			checks++;
			assert (ack === 1'b0 && result === expected) else begin
				errors++;
				$display("[ERROR] %0d ns: idle ack %b result %h, expected 0 and %h",
					$time, ack, result, expected);
			end
		end
	endtask

	initial begin
		clk     = 1'b0;
		reset   = 1'b1;
		req     = 1'b0;
		data    = '0;
		seed    = 32'hc05a_35ea;
		checks  = 0;
		errors  = 0;
		n_tests = 0;
		mark_checks = 0;
		mark_errors = 0;
		$readmemh(WEIGHT_FILE, weights);
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		@(negedge clk);
		checks++;
		assert (ack === 1'b0 && result === BF16_ZERO) else begin
			errors++;
			$display("[ERROR] %0d ns: after reset ack %b result %h, expected 0 and 0000",
				$time, ack, result);
		end
		report_test("reset state");

		run_word('0, BF16_ZERO, 0);
		for (int i = 0; i < N_INPUTS; i++) begin
			word    = '0;
			word[i] = 1'b1;
			run_word(word, weights[i], 0);          // Exactly the selected weight
		end
		run_word('1, neuron_ref('1), 0);
		report_test("corner words");

		for (int i = 0; i < N_HALF; i++) begin
			word = random_word() & LOW_MASK;
			run_word(word, neuron_ref(word), 0);
			word = random_word() & ~LOW_MASK;
			run_word(word, neuron_ref(word), 0);
		end
		report_test("lane halves");

		for (int i = 0; i < N_RANDOM; i++) begin
			word = random_word();
			run_word(word, neuron_ref(word), 0);
		end
		report_test("random words");

		for (int i = 0; i < N_HS; i++) begin
			word = random_word();
			run_word(word, neuron_ref(word), 0);
			idle_check($random(seed) & 3, neuron_ref(word));
		end
		report_test("handshake");

		for (int i = 0; i < N_BP; i++) begin
			word = random_word();
			hold = $random(seed) & MAX_HOLD;
			run_word(word, neuron_ref(word), hold);
		end
		report_test("back-pressure");

		$display("Summary: %0d tests, %0d checks, %0d errors", n_tests, checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+.
npu_pkg.sv
bf16_add.sv
weight_rom.sv
dot_lane.sv
neuron_core.sv
tb_neuron_core.sv

//--- weight_rom.sv
`timescale 1ns/100ps

module weight_rom (
	input  logic                       clk,
	input  logic [npu_pkg::ADDR_W-1:0] addr_a,
	output npu_pkg::bf16_t             data_a,
	input  logic [npu_pkg::ADDR_W-1:0] addr_b,
	output npu_pkg::bf16_t             data_b
);
	import npu_pkg::*;

	bf16_t mem [0:(1 << ADDR_W)-1];   // One weight per activation bit

	initial begin
		$readmemh(WEIGHT_FILE, mem);
	end

	// Port a serves lane 0, port b lane 1
	always_ff @(posedge clk) begin
		data_a <= mem[addr_a];
		data_b <= mem[addr_b];
	end

endmodule

//--- weights.hex
// One bfloat16 weight per line in hex (sign, exponent, mantissa)
// Line n below holds the weight for activation bit n
3F80
BF20
3E9A
4013
BEC4
3F4D
C00A
3DCC
3FB3
BE66
3F19
C03E
3E4C
3FE6
BF8C
4026
BD99
3F33
BFA6
3E1A
4049
BF59
3EB8
C01F
3FC0
BE8F
3F6B
BF0F
401A
3D4C
BFE0
3F26
C005
3F9A
BE29
3ECD
4033
BF73
3E05
BFB9
3F47
C02C
3DF5
3F8E
BEA3
4008
BF3D
3E70
3FD2
BE14
C014
3F60
3E61
BF99
4040
BDB8
3F0A
BFC7
3EE1
C01B
3F85
BE3D
3FA0
BF80
